/* plsv_pkg.sv */
package plsv_pkg;

	// local-bus word address width
	localparam int LB_ADDR_W = 8;

	// axi side
	typedef logic [31:0] axi_addr_t;
	typedef logic [LB_ADDR_W-1:0] lb_addr_t;
	typedef logic [31:0] lb_data_t;
	typedef logic [3:0] axi_strb_t;
	typedef logic [1:0] axi_resp_t;

	localparam axi_resp_t RESP_OKAY = 2'b00;
	localparam axi_resp_t RESP_SLVERR = 2'b10;

	// stream side, four 64-bit dac lanes and four 16-bit adc samples
	typedef logic [255:0] dac_data_t;
	typedef logic [31:0] dac_strb_t;
	typedef logic [63:0] adc_data_t;
	typedef logic [7:0] adc_strb_t;
	typedef logic [31:0] beat_count_t;

	// master to slave
	typedef struct packed {
		axi_addr_t awaddr;
		logic awvalid;
		lb_data_t wdata;
		axi_strb_t wstrb;
		logic wvalid;
		logic bready;
		axi_addr_t araddr;
		logic arvalid;
		logic rready;
	} axi_req_t;

	// slave to master
	typedef struct packed {
		logic awready;
		logic wready;
		logic bvalid;
		axi_resp_t bresp;
		logic arready;
		logic rvalid;
		lb_data_t rdata;
		axi_resp_t rresp;
	} axi_rsp_t;

	typedef struct packed {
		lb_addr_t waddr;
		lb_data_t wdata;
		axi_strb_t wstrb;
		logic wren;
		lb_addr_t raddr;
		logic rden;
	} lb_req_t;

	// err flags an unmapped address
	typedef struct packed {
		lb_data_t rdata;
		logic rvalid;
		logic err;
	} lb_rsp_t;

	typedef struct packed {
		logic tvalid;
		dac_data_t tdata;
		dac_strb_t tstrb;
		logic tlast;
	} dac_stream_t;

	typedef struct packed {
		logic tvalid;
		adc_data_t tdata;
		adc_strb_t tstrb;
		logic tlast;
	} adc_stream_t;

	typedef enum logic [2:0] {
		IDLE,
		WR_STROBE,
		WR_RESP,
		RD_STROBE,
		RD_WAIT,
		RD_DATA
	} bridge_state_t;

	// register map, word addresses
	localparam lb_addr_t REG_RESETS = 8'd0;
	localparam lb_addr_t REG_LOOP_CTRL = 8'd1;
	localparam lb_addr_t REG_BEAT_COUNT = 8'd2;
	localparam lb_addr_t REG_ID = 8'd3;

	localparam lb_data_t PLSV_ID = 32'h504c5356;

endpackage

/* axi_lb_bridge.sv */
`timescale 1ns/1ps

module axi_lb_bridge import plsv_pkg::*; (
	input logic pl_clk0,
	input logic reset,
	input axi_req_t axi_req,
	output axi_rsp_t axi_rsp,
	output lb_req_t lb_req,
	input lb_rsp_t lb_rsp
);

	bridge_state_t state;
	bridge_state_t state_d;

	// latched transfer
	lb_addr_t addr_q;
	lb_data_t wdata_q;
	axi_strb_t strb_q;
	lb_data_t rdata_q;
	axi_resp_t resp_q;

	logic wr_accept;
	logic rd_accept;

	// write needs aw and w together, and wins over a pending read
	assign wr_accept = (state == IDLE) && axi_req.awvalid && axi_req.wvalid;
	assign rd_accept = (state == IDLE) && axi_req.arvalid && !wr_accept;

	always_comb begin
		state_d = state;
		case (state)
			IDLE: begin
				if (wr_accept) begin
					state_d = WR_STROBE;
				end else if (rd_accept) begin
					state_d = RD_STROBE;
				end
			end
			// one wren cycle, then response
			WR_STROBE: state_d = WR_RESP;
			WR_RESP: begin
				if (axi_req.bready) begin
					state_d = IDLE;
				end
			end
			RD_STROBE: state_d = RD_WAIT;
			// regs answer one cycle after rden
			RD_WAIT: begin
				if (lb_rsp.rvalid) begin
					state_d = RD_DATA;
				end
			end
			RD_DATA: begin
				if (axi_req.rready) begin
					state_d = IDLE;
				end
			end
			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge pl_clk0) begin
		if (reset) begin
			state <= IDLE;
		end else begin
			state <= state_d;
		end
	end

	// payload capture
	always_ff @(posedge pl_clk0) begin
		if (wr_accept) begin
			// byte address to word address
			addr_q <= axi_req.awaddr[LB_ADDR_W+1:2];
			wdata_q <= axi_req.wdata;
			strb_q <= axi_req.wstrb;
		end else if (rd_accept) begin
			addr_q <= axi_req.araddr[LB_ADDR_W+1:2];
		end
		// write err is valid alongside wren
		if (state == WR_STROBE) begin
			resp_q <= lb_rsp.err ? RESP_SLVERR : RESP_OKAY;
		end
		if (state == RD_WAIT && lb_rsp.rvalid) begin
			rdata_q <= lb_rsp.rdata;
			resp_q <= lb_rsp.err ? RESP_SLVERR : RESP_OKAY;
		end
	end

	// axi handshakes
	assign axi_rsp.awready = wr_accept;
	assign axi_rsp.wready = wr_accept;
	assign axi_rsp.arready = rd_accept;
	assign axi_rsp.bvalid = (state == WR_RESP);
	assign axi_rsp.bresp = resp_q;
	assign axi_rsp.rvalid = (state == RD_DATA);
	assign axi_rsp.rdata = rdata_q;
	assign axi_rsp.rresp = resp_q;

	// local-bus strobes
	assign lb_req.waddr = addr_q;
	assign lb_req.wdata = wdata_q;
	assign lb_req.wstrb = strb_q;
	assign lb_req.wren = (state == WR_STROBE);
	assign lb_req.raddr = addr_q;
	assign lb_req.rden = (state == RD_STROBE);

	// response held until taken
	a_bvalid_hold: assert property (@(posedge pl_clk0) disable iff (reset)
		axi_rsp.bvalid && !axi_req.bready |=> axi_rsp.bvalid);

	a_rdata_hold: assert property (@(posedge pl_clk0) disable iff (reset)
		axi_rsp.rvalid && !axi_req.rready |=> axi_rsp.rvalid && $stable(axi_rsp.rdata));

endmodule

/* cfg_regs.sv */
`timescale 1ns/1ps

module cfg_regs import plsv_pkg::*; #(
	parameter int N_RESETS = 8
) (
	input logic pl_clk0,
	input logic reset,
	input lb_req_t lb_req,
	output lb_rsp_t lb_rsp,
	output logic [N_RESETS-1:0] cfg_resetn,
	output logic loop_en,
	output logic count_clear,
	input beat_count_t beat_count
);

	lb_data_t resets_q;
	lb_data_t rdata_q;
	logic rvalid_q;
	logic rd_err_q;
	logic wr_resets;
	logic wr_ctrl;

	function automatic logic is_mapped(lb_addr_t addr);
		return addr inside {REG_RESETS, REG_LOOP_CTRL, REG_BEAT_COUNT, REG_ID};
	endfunction

	// write decode, read-only and unmapped words fall through
	assign wr_resets = lb_req.wren && (lb_req.waddr == REG_RESETS);
	assign wr_ctrl = lb_req.wren && (lb_req.waddr == REG_LOOP_CTRL);

	always_ff @(posedge pl_clk0) begin
		if (reset) begin
			resets_q <= '0;
			loop_en <= 1'b0;
			count_clear <= 1'b0;
		end else begin
			// bit 1 is self-clearing, so only a pulse
			count_clear <= wr_ctrl && lb_req.wstrb[0] && lb_req.wdata[1];
			if (wr_resets) begin
				// per-byte merge
				for (int b = 0; b < 4; b++) begin
					if (lb_req.wstrb[b]) begin
						resets_q[8*b +: 8] <= lb_req.wdata[8*b +: 8];
					end
				end
			end
			if (wr_ctrl && lb_req.wstrb[0]) begin
				loop_en <= lb_req.wdata[0];
			end
		end
	end

	// read response one cycle after rden
	always_ff @(posedge pl_clk0) begin
		if (reset) begin
			rvalid_q <= 1'b0;
			rd_err_q <= 1'b0;
		end else begin
			rvalid_q <= lb_req.rden;
			rd_err_q <= lb_req.rden && !is_mapped(lb_req.raddr);
		end
	end

	always_ff @(posedge pl_clk0) begin
		if (lb_req.rden) begin
			case (lb_req.raddr)
				REG_RESETS: rdata_q <= resets_q;
				// clear bit reads back as 0
				REG_LOOP_CTRL: rdata_q <= {31'b0, loop_en};
				REG_BEAT_COUNT: rdata_q <= beat_count;
				REG_ID: rdata_q <= PLSV_ID;
				default: rdata_q <= '0;
			endcase
		end
	end

	assign lb_rsp.rdata = rdata_q;
	assign lb_rsp.rvalid = rvalid_q;
	// write err same cycle as wren
	assign lb_rsp.err = rd_err_q || (lb_req.wren && !is_mapped(lb_req.waddr));

	// low bits straight out, 0 holds the block in reset
	assign cfg_resetn = resets_q[N_RESETS-1:0];

	// bridge issues one strobe at a time
	a_one_strobe: assert property (@(posedge pl_clk0) disable iff (reset)
		!(lb_req.wren && lb_req.rden));

endmodule

/* dac_adc_loopback.sv */
`timescale 1ns/1ps

module dac_adc_loopback import plsv_pkg::*; (
	input logic pl_clk0,
	input logic reset,
	input logic loop_en,
	input logic count_clear,
	input dac_stream_t dac,
	output logic dac_tready,
	output adc_stream_t adc,
	input logic adc_tready,
	output beat_count_t beat_count
);

	adc_data_t repack_data;
	adc_strb_t repack_strb;
	// one-entry output stage
	logic valid_q;
	adc_data_t data_q;
	adc_strb_t strb_q;
	logic last_q;
	logic dac_fire;
	logic adc_fire;

	// low 16 bits of each 64-bit lane, every fourth strobe bit
	always_comb begin
		for (int k = 0; k < 4; k++) begin
			repack_data[16*k +: 16] = dac.tdata[64*k +: 16];
		end
		for (int j = 0; j < 8; j++) begin
			repack_strb[j] = dac.tstrb[4*j];
		end
	end

	// accept when empty or draining this cycle
	assign dac_tready = loop_en && (!valid_q || adc_tready);
	assign dac_fire = dac.tvalid && dac_tready;
	assign adc_fire = valid_q && adc_tready;

	always_ff @(posedge pl_clk0) begin
		if (reset) begin
			valid_q <= 1'b0;
		end else if (dac_fire) begin
			valid_q <= 1'b1;
		end else if (adc_fire) begin
			valid_q <= 1'b0;
		end
	end

	always_ff @(posedge pl_clk0) begin
		if (dac_fire) begin
			data_q <= repack_data;
			strb_q <= repack_strb;
			last_q <= dac.tlast;
		end
	end

	// adc handshakes, wraps
	always_ff @(posedge pl_clk0) begin
		if (reset || count_clear) begin
			beat_count <= '0;
		end else if (adc_fire) begin
			beat_count <= beat_count + 1'b1;
		end
	end

	assign adc.tvalid = valid_q;
	assign adc.tdata = data_q;
	assign adc.tstrb = strb_q;
	assign adc.tlast = last_q;

	// stalled beat stays put
	a_adc_stall: assert property (@(posedge pl_clk0) disable iff (reset)
		adc.tvalid && !adc_tready |=> adc.tvalid && $stable(adc));

endmodule

/* plsv_top.sv */
`timescale 1ns/1ps

module plsv_top import plsv_pkg::*; #(
	parameter int N_RESETS = 8
) (
	input logic pl_clk0,
	input logic reset,
	input axi_req_t axi_req,
	output axi_rsp_t axi_rsp,
	output logic [N_RESETS-1:0] cfg_resetn,
	input dac_stream_t dac,
	output logic dac_tready,
	output adc_stream_t adc,
	input logic adc_tready
);

	// bridge to register block
	lb_req_t lb_req;
	lb_rsp_t lb_rsp;

	// register block to loopback
	logic loop_en;
	logic count_clear;
	beat_count_t beat_count;

	axi_lb_bridge u_bridge (
		.pl_clk0 (pl_clk0),
		.reset   (reset),
		.axi_req (axi_req),
		.axi_rsp (axi_rsp),
		.lb_req  (lb_req),
		.lb_rsp  (lb_rsp)
	);

	cfg_regs #(
		.N_RESETS (N_RESETS)
	) u_regs (
		.pl_clk0     (pl_clk0),
		.reset       (reset),
		.lb_req      (lb_req),
		.lb_rsp      (lb_rsp),
		.cfg_resetn  (cfg_resetn),
		.loop_en     (loop_en),
		.count_clear (count_clear),
		.beat_count  (beat_count)
	);

	// dac beats back in as adc beats
	dac_adc_loopback u_loopback (
		.pl_clk0     (pl_clk0),
		.reset       (reset),
		.loop_en     (loop_en),
		.count_clear (count_clear),
		.dac         (dac),
		.dac_tready  (dac_tready),
		.adc         (adc),
		.adc_tready  (adc_tready),
		.beat_count  (beat_count)
	);

endmodule

/* plsv_top_tb.sv */
`timescale 1ns/1ps

module plsv_top_tb import plsv_pkg::*; ();

	localparam int N_RESETS = 8;
	// cycles before any single wait gives up
	localparam int TIMEOUT = 200;

	logic pl_clk0;
	logic reset;
	axi_req_t axi_req;
	axi_rsp_t axi_rsp;
	logic [N_RESETS-1:0] cfg_resetn;
	dac_stream_t dac;
	logic dac_tready;
	adc_stream_t adc;
	logic adc_tready;

	// bookkeeping for the current test line
	string cur_name;
	int test_errs;
	int errors;
	int tests;
	int failed;
	logic timed_out;

	plsv_top #(
		.N_RESETS (N_RESETS)
	) u_dut (
		.pl_clk0    (pl_clk0),
		.reset      (reset),
		.axi_req    (axi_req),
		.axi_rsp    (axi_rsp),
		.cfg_resetn (cfg_resetn),
		.dac        (dac),
		.dac_tready (dac_tready),
		.adc        (adc),
		.adc_tready (adc_tready)
	);

	// 8 ns clock
	initial begin
		pl_clk0 = 1'b0;
		forever #4 pl_clk0 = ~pl_clk0;
	end

	task automatic compare_value(input string what, input logic [95:0] want,
			input logic [95:0] got);
		assert (got === want) else begin
			$display("ERR %s %s expected %0h actual %0h", cur_name, what, want, got);
			test_errs++;
		end
	endtask

	task automatic report_timeout(input string what);
		$display("%s: no %s within %0d cycles, giving up", cur_name, what, TIMEOUT);
		test_errs++;
		timed_out = 1'b1;
	endtask

	// 0 awready, 1 bvalid, 2 arready, 3 rvalid
	function automatic logic probe(input int sel);
		case (sel)
			0: return axi_rsp.awready;
			1: return axi_rsp.bvalid;
			2: return axi_rsp.arready;
			default: return axi_rsp.rvalid;
		endcase
	endfunction

	// sampled mid-cycle so the handshake lands on the next rising edge
	task automatic wait_high(input int sel, input string what, output logic ok);
		int n;
		n = 0;
		@(negedge pl_clk0);
		while (!probe(sel) && n < TIMEOUT) begin
			@(negedge pl_clk0);
			n++;
		end
		ok = probe(sel);
		if (!ok) begin
			report_timeout(what);
		end
	endtask

	task automatic axi_write(input axi_addr_t addr, input lb_data_t data, input axi_strb_t strb,
			input axi_resp_t want_resp);
		logic ok;
		axi_req.awaddr = addr;
		axi_req.awvalid = 1'b1;
		axi_req.wdata = data;
		axi_req.wstrb = strb;
		axi_req.wvalid = 1'b1;
		wait_high(0, "awready", ok);
		if (!ok) begin
			return;
		end
		// aw and w are taken on the same edge
		compare_value("wready", 96'(1'b1), 96'(axi_rsp.wready));
		@(posedge pl_clk0);
		#1;
		axi_req.awvalid = 1'b0;
		axi_req.wvalid = 1'b0;
		axi_req.bready = 1'b1;
		wait_high(1, "bvalid", ok);
		if (ok) begin
			compare_value("bresp", 96'(want_resp), 96'(axi_rsp.bresp));
		end
		@(posedge pl_clk0);
		#1;
		axi_req.bready = 1'b0;
	endtask

	task automatic axi_read(input axi_addr_t addr, input lb_data_t want_data,
			input axi_resp_t want_resp);
		logic ok;
		axi_req.araddr = addr;
		axi_req.arvalid = 1'b1;
		wait_high(2, "arready", ok);
		if (!ok) begin
			return;
		end
		@(posedge pl_clk0);
		#1;
		axi_req.arvalid = 1'b0;
		axi_req.rready = 1'b1;
		wait_high(3, "rvalid", ok);
		if (ok) begin
			compare_value("rdata", 96'(want_data), 96'(axi_rsp.rdata));
			compare_value("rresp", 96'(want_resp), 96'(axi_rsp.rresp));
		end
		@(posedge pl_clk0);
		#1;
		axi_req.rready = 1'b0;
	endtask

	task automatic expect_resetn(input logic [N_RESETS-1:0] want);
		@(negedge pl_clk0);
		compare_value("cfg_resetn", 96'(want), 96'(cfg_resetn));
		@(posedge pl_clk0);
		#1;
	endtask

	// expected adc beat takes sample k from the low 16 bits of dac lane k
	function automatic adc_stream_t lane_map(input dac_stream_t d);
		adc_stream_t a;
		a.tvalid = 1'b1;
		a.tdata = {d.tdata[207:192], d.tdata[143:128], d.tdata[79:64], d.tdata[15:0]};
		a.tstrb = {d.tstrb[28], d.tstrb[24], d.tstrb[20], d.tstrb[16],
			d.tstrb[12], d.tstrb[8], d.tstrb[4], d.tstrb[0]};
		a.tlast = d.tlast;
		return a;
	endfunction

	task automatic random_dac_beat();
		for (int i = 0; i < 8; i++) begin
			dac.tdata[32*i +: 32] = $urandom;
		end
		dac.tstrb = $urandom;
		dac.tlast = ($urandom & 32'd1) != 0;
		dac.tvalid = 1'b1;
	endtask

	task automatic run_stream(input int count, input logic backpressure);
		adc_stream_t want_q[$];
		adc_stream_t want;
		int sent;
		int got;
		int idle;
		logic dac_take;
		logic adc_take;
		sent = 0;
		got = 0;
		idle = 0;
		// idle counts cycles since the last adc beat
		while (got < count && idle < TIMEOUT) begin
			if (!dac.tvalid && sent < count) begin
				random_dac_beat();
			end
			adc_tready = backpressure ? (($urandom & 32'd1) != 0) : 1'b1;
			@(negedge pl_clk0);
			dac_take = dac.tvalid && dac_tready;
			adc_take = adc.tvalid && adc_tready;
			// adc side first since its beat left the dac side on an earlier edge
			if (adc_take) begin
				if (want_q.size() == 0) begin
					$display("%s: ADC beat arrived with no DAC beat outstanding", cur_name);
					test_errs++;
				end else begin
					want = want_q.pop_front();
					compare_value("adc beat", 96'({want.tdata, want.tstrb, want.tlast}),
						96'({adc.tdata, adc.tstrb, adc.tlast}));
				end
				got++;
				idle = 0;
			end else begin
				idle++;
			end
			if (dac_take) begin
				want_q.push_back(lane_map(dac));
				sent++;
			end
			@(posedge pl_clk0);
			#1;
			if (dac_take) begin
				dac.tvalid = 1'b0;
			end
		end
		dac.tvalid = 1'b0;
		adc_tready = 1'b1;
		if (idle >= TIMEOUT) begin
			report_timeout("ADC beat");
		end else begin
			@(negedge pl_clk0);
			compare_value("beats left over", 96'(0), 96'(want_q.size()));
			compare_value("adc tvalid after last beat", 96'(1'b0), 96'(adc.tvalid));
			@(posedge pl_clk0);
			#1;
		end
	endtask

	// nothing may move while dac valid is held high
	task automatic hold_disabled(input int cycles);
		random_dac_beat();
		adc_tready = 1'b1;
		for (int c = 0; c < cycles; c++) begin
			@(negedge pl_clk0);
			compare_value("dac_tready", 96'(1'b0), 96'(dac_tready));
			compare_value("adc tvalid", 96'(1'b0), 96'(adc.tvalid));
			@(posedge pl_clk0);
			#1;
		end
		dac.tvalid = 1'b0;
	endtask

	initial begin
		int fd;
		int code;
		string line;
		string cmd;
		string name;
		logic [31:0] f0;
		logic [31:0] f1;
		logic [31:0] f2;
		logic [31:0] f3;
		void'($urandom(32'hce3b));
		errors = 0;
		tests = 0;
		failed = 0;
		test_errs = 0;
		timed_out = 1'b0;
		cur_name = "setup";
		axi_req = '0;
		dac = '0;
		adc_tready = 1'b0;
		reset = 1'b1;
		repeat (8) @(posedge pl_clk0);
		#1;
		reset = 1'b0;

		fd = $fopen("plsv_tests.txt", "r");
		if (fd == 0) begin
			$display("could not open plsv_tests.txt");
			errors++;
		end else begin
			while (!$feof(fd) && !timed_out) begin
				code = $fgets(line, fd);
				// blank and comment lines
				if (code == 0 || line.len() < 2 || line.getc(0) == "#") begin
					continue;
				end
				f0 = '0;
				f1 = '0;
				f2 = '0;
				f3 = '0;
				code = $sscanf(line, "%s %s %h %h %h %h", cmd, name, f0, f1, f2, f3);
				cur_name = name;
				test_errs = 0;
				case (cmd)
					"W": axi_write(f0, f1, f2[3:0], f3[1:0]);
					"R": axi_read(f0, f1, f2[1:0]);
					"C": expect_resetn(f0[N_RESETS-1:0]);
					"L": run_stream(int'(f0), f1[0]);
					"X": hold_disabled(int'(f0));
					default: begin
						$display("%s: unknown command %s in plsv_tests.txt", name, cmd);
						test_errs++;
					end
				endcase
				tests++;
				errors += test_errs;
				if (test_errs != 0) begin
					failed++;
					$display("FAIL %s", name);
				end else begin
					$display("ok   %s", name);
				end
			end
			$fclose(fd);
		end

		$display("tests run %0d, tests failed %0d, check errors %0d", tests, failed, errors);
		if (errors == 0 && !timed_out && tests > 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

/* plsv_tests.txt */
# cmd name, then hex fields: W addr data strb bresp, R addr rdata rresp
# C resetn, L beats backpressure, X cycles
C resetn_after_reset 00
R resets_after_reset 00000000 00000000 0
R id_after_reset 0000000c 504c5356 0
W resets_full_write 00000000 a5c3e17f f 0
C resetn_full_write 7f
W resets_byte_write 00000000 12345699 5 0
R resets_merged 00000000 a534e199 0
C resetn_merged 99
W unmapped_write 00000040 deadbeef f 2
R unmapped_read 00000040 00000000 2
W id_write 0000000c ffffffff f 0
R id_unchanged 0000000c 504c5356 0
W loop_enable 00000004 00000001 f 0
L stream_backpressure 20 1
L stream_full_rate 10 0
R beat_count 00000008 00000030 0
W count_clear 00000004 00000003 f 0
R beat_count_cleared 00000008 00000000 0
R loop_ctrl_readback 00000004 00000001 0
W loop_disable 00000004 00000000 f 0
X stream_disabled 40

/* plsv_top.f */
plsv_pkg.sv
axi_lb_bridge.sv
cfg_regs.sv
dac_adc_loopback.sv
plsv_top.sv
plsv_top_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f plsv_top.f \
	--top-module plsv_top_tb -o plsv_sim
./obj_dir/plsv_sim | tee sim.log

if grep -q "Finished with no errors" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
